// File: exe_pipe.f
exe_pkg.sv
alu.sv
id_stage.sv
exe_stage.sv
exe_pipe.sv
exe_pipe_tb.sv

// File: exe_pipe_tb.sv
module exe_pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import exe_pkg::*;

    localparam int issue_limit = 100; // cycles an issue may wait for ready
    localparam int drain_limit = 400; // cycles to empty the pipeline

    logic                   clk;
    logic                   rst;
    logic                   issue_valid;
    logic                   issue_ready;
    logic [xlen-1:0]        inst;
    logic [xlen-1:0]        pc;
    logic [xlen-1:0]        rj_value;
    logic [xlen-1:0]        rk_value;
    logic                   wb_valid;
    logic                   wb_ready;
    logic [xlen-1:0]        wb_data;
    logic                   wb_we;
    logic [reg_index_w-1:0] wb_index;
    logic [xlen-1:0]        wb_pc;

    integer       seed;
    integer       ready_seed;
    int           errors;
    int           checks;
    int           tests_run;
    bit           timed_out;
    bit           bp_random;   // writeback ready toggled at random
    bit           stalled;
    logic [69:0]  held;        // {data, we, index, pc}
    logic [69:0]  exp_item;
    logic [69:0]  exp_q[$];    // expected writebacks in issue order
    logic [31:0]  edge_vals[0:3];

    exe_pipe i_exe_pipe (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .inst        (inst),
        .pc          (pc),
        .rj_value    (rj_value),
        .rk_value    (rk_value),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_data     (wb_data),
        .wb_we       (wb_we),
        .wb_index    (wb_index),
        .wb_pc       (wb_pc)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (bp_random) begin
            wb_ready = ($random(ready_seed) & 1) == 1;
        end
    end

    // expected writeback packed as {data, we, index, pc}
    function automatic logic [69:0] model(input logic [31:0] i_inst, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:0] p);
        logic [3:0]  code;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [31:0] imm;
        logic [31:0] opb;
        logic [31:0] res;
        logic        ok;
        code = i_inst[31:28];
        rd   = i_inst[26:22];
        if (code == op_lui) begin
            imm = {i_inst[15:0], 16'h0000};
        end else begin
            imm = {{16{i_inst[15]}}, i_inst[15:0]};
        end
        opb = i_inst[27] ? imm : b;
        sh  = opb[4:0];
        ok  = 1'b1;
        case (code)
            op_add:  res = a + opb;
            op_sub:  res = a + ~opb + 32'd1;
            op_slt:  res = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
            op_sltu: res = (a < opb) ? 32'd1 : 32'd0;
            op_and:  res = a & opb;
            op_or:   res = a | opb;
            op_nor:  res = ~(a | opb);
            op_xor:  res = a ^ opb;
            op_sll:  res = a << sh;
            op_srl:  res = a >> sh;
            op_sra: begin
                res = a >> sh;
                if (a[31]) begin
                    res = res | ~(32'hffff_ffff >> sh); // fill vacated bits with sign
                end
            end
            op_lui:  res = opb;
            default: begin
                res = 32'd0;
                ok  = 1'b0;
            end
        endcase
        return {res, ok && (rd != 5'd0), rd, p};
    endfunction

    function automatic logic [31:0] build_inst(input logic [3:0] code, input logic use_imm,
                                               input logic [4:0] rd, input logic [21:0] low);
        return {code, use_imm, rd, low};
    endfunction

    // scoreboard and stall stability, sampled on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                if (!wb_valid) begin
                    errors++;
                    $display("wb_valid dropped while writeback was stalled at %0t", $time);
                end else if ({wb_data, wb_we, wb_index, wb_pc} !== held) begin
                    errors++;
                    $display("[ERROR] t=%0t wb outputs while stalled expected %h actual %h",
                             $time, held, {wb_data, wb_we, wb_index, wb_pc});
                end
            end
            if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("writeback at %0t with no item outstanding", $time);
                end else begin
                    exp_item = exp_q.pop_front();
                    checks++;
                    if (wb_data !== exp_item[69:38]) begin
                        errors++;
                        $display("[ERROR] t=%0t wb_data expected %h actual %h",
                                 $time, exp_item[69:38], wb_data);
                    end
                    if (wb_we !== exp_item[37]) begin
                        errors++;
                        $display("[ERROR] t=%0t wb_we expected %b actual %b",
                                 $time, exp_item[37], wb_we);
                    end
                    if (wb_index !== exp_item[36:32]) begin
                        errors++;
                        $display("[ERROR] t=%0t wb_index expected %0d actual %0d",
                                 $time, exp_item[36:32], wb_index);
                    end
                    if (wb_pc !== exp_item[31:0]) begin
                        errors++;
                        $display("[ERROR] t=%0t wb_pc expected %h actual %h",
                                 $time, exp_item[31:0], wb_pc);
                    end
                end
            end
            stalled = wb_valid && !wb_ready;
            held    = {wb_data, wb_we, wb_index, wb_pc};
        end
    end

    // called just after a falling edge, returns on the next falling edge
    task automatic issue_item(input logic [31:0] i_inst, input logic [31:0] i_pc,
                              input logic [31:0] a, input logic [31:0] b);
        int waited;
        waited = 0;
        if (timed_out) begin
            return;
        end
        inst        = i_inst;
        pc          = i_pc;
        rj_value    = a;
        rk_value    = b;
        issue_valid = 1'b1;
        @(posedge clk);
        while (!issue_ready && waited < issue_limit) begin
            waited++;
            @(posedge clk);
        end
        if (!issue_ready) begin
            errors++;
            timed_out = 1'b1;
            $display("issue at %0t was never accepted within %0d cycles", $time, issue_limit);
        end else begin
            exp_q.push_back(model(i_inst, a, b, i_pc));
        end
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || wb_valid) && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || wb_valid) begin
            errors++;
            timed_out = 1'b1;
            $display("%s did not drain in %0d cycles, %0d items still outstanding",
                     what, drain_limit, exp_q.size());
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%-22s done, no errors", name);
        end else begin
            $display("%-22s done, %0d errors", name, errors - err_before);
        end
    endtask

    task automatic reset_state_check();
        int err_before;
        err_before = errors;
        if (wb_valid !== 1'b0) begin
            errors++;
            $display("[ERROR] t=%0t wb_valid expected 0 actual %b", $time, wb_valid);
        end
        if (issue_ready !== 1'b1) begin
            errors++;
            $display("[ERROR] t=%0t issue_ready expected 1 actual %b", $time, issue_ready);
        end
        report_test("reset state", err_before);
    endtask

    task automatic stream_random();
        int          err_before;
        logic [31:0] word;
        err_before = errors;
        wb_ready   = 1'b1;
        for (int i = 0; i < 200 && !timed_out; i++) begin
            word = $random(seed);
            word = build_inst(4'(i % 12), 1'((i / 12) % 2), word[26:22], word[21:0]);
            issue_item(word, 32'h0000_1000 + 4 * i, $random(seed), $random(seed));
        end
        wait_drain("streaming");
        report_test("streaming", err_before);
    endtask

    task automatic edge_operand_sweep();
        int          err_before;
        logic [31:0] word;
        err_before   = errors;
        edge_vals[0] = 32'h0000_0000;
        edge_vals[1] = 32'hffff_ffff;
        edge_vals[2] = 32'h8000_0000;
        edge_vals[3] = 32'h0000_001f; // shift by 31
        for (int op = 0; op < 12 && !timed_out; op++) begin
            for (int a = 0; a < 4; a++) begin
                for (int b = 0; b < 4; b++) begin
                    word = build_inst(4'(op), 1'b0, 5'd3, 22'h0);
                    issue_item(word, 32'h0000_2000 + 4 * op, edge_vals[a], edge_vals[b]);
                end
            end
            // immediates at the sign boundary
            issue_item(build_inst(4'(op), 1'b1, 5'd4, 22'h8000), 32'h0000_3000,
                       edge_vals[2], 32'h0);
            issue_item(build_inst(4'(op), 1'b1, 5'd5, 22'hffff), 32'h0000_3004,
                       edge_vals[1], 32'h0);
        end
        wait_drain("edge operands");
        report_test("edge operands", err_before);
    endtask

    task automatic no_write_items();
        int          err_before;
        logic [31:0] word;
        logic [4:0]  rd;
        err_before = errors;
        for (int i = 0; i < 40 && !timed_out; i++) begin
            word = $random(seed);
            rd   = (word[26:22] == 5'd0) ? 5'd9 : word[26:22];
            issue_item(build_inst(4'(12 + i % 4), word[27], rd, word[21:0]),
                       32'h0000_4000 + 4 * i, $random(seed), $random(seed));
        end
        // defined opcodes aimed at r0
        for (int i = 0; i < 24 && !timed_out; i++) begin
            word = $random(seed);
            issue_item(build_inst(4'(i % 12), 1'((i / 12) % 2), 5'd0, word[21:0]),
                       32'h0000_4100 + 4 * i, $random(seed), $random(seed));
        end
        wait_drain("no-write items");
        report_test("undefined and r0", err_before);
    endtask

    task automatic random_backpressure();
        int          err_before;
        logic [31:0] word;
        err_before = errors;
        bp_random  = 1'b1;
        for (int i = 0; i < 300 && !timed_out; i++) begin
            while (($random(seed) & 3) == 0) begin
                @(negedge clk); // idle issue cycle
            end
            word = $random(seed);
            word[31:28] = 4'($unsigned($random(seed)) % 16);
            issue_item(word, 32'h0001_0000 + 4 * i, $random(seed), $random(seed));
        end
        bp_random = 1'b0;
        @(negedge clk);
        wb_ready = 1'b1;
        wait_drain("back-pressure");
        report_test("random back-pressure", err_before);
    endtask

    task automatic full_stall_drain();
        int err_before;
        err_before = errors;
        wb_ready   = 1'b0;
        issue_item(build_inst(op_add, 1'b1, 5'd1, 22'h0011), 32'h0002_0000, 32'd5, 32'd0);
        if (issue_ready !== 1'b1) begin
            errors++;
            $display("[ERROR] t=%0t issue_ready expected 1 actual %b", $time, issue_ready);
        end
        issue_item(build_inst(op_xor, 1'b0, 5'd2, 22'h0), 32'h0002_0004, 32'hf0f0, 32'h0ff0);
        for (int k = 0; k < 6; k++) begin
            if (issue_ready !== 1'b0) begin
                errors++;
                $display("[ERROR] t=%0t issue_ready expected 0 actual %b", $time, issue_ready);
            end
            if (wb_valid !== 1'b1) begin
                errors++;
                $display("[ERROR] t=%0t wb_valid expected 1 actual %b", $time, wb_valid);
            end
            @(negedge clk);
        end
        wb_ready = 1'b1;
        wait_drain("full stall");
        report_test("full stall", err_before);
    endtask

    task automatic finish_run();
        $display("%0d tests run, %0d items checked, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        inst        = '0;
        pc          = '0;
        rj_value    = '0;
        rk_value    = '0;
        wb_ready    = 1'b1;
        bp_random   = 1'b0;
        timed_out   = 1'b0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        seed        = 32'h3a9e_2a89;
        ready_seed  = seed ^ 32'h0f0f_0f0f; // separate stream for wb_ready
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state_check();
        if (!timed_out) stream_random();
        if (!timed_out) edge_operand_sweep();
        if (!timed_out) no_write_items();
        if (!timed_out) random_backpressure();
        if (!timed_out) full_stall_drain();
        finish_run();
    end

endmodule

// File: exe_pipe.sv
module exe_pipe (
    input  logic                              clk,
    input  logic                              rst,
    // issue side
    input  logic                              issue_valid,
    output logic                              issue_ready,
    input  logic [exe_pkg::xlen-1:0]          inst,
    input  logic [exe_pkg::xlen-1:0]          pc,
    input  logic [exe_pkg::xlen-1:0]          rj_value,
    input  logic [exe_pkg::xlen-1:0]          rk_value,
    // writeback side
    output logic                              wb_valid,
    input  logic                              wb_ready,
    output logic [exe_pkg::xlen-1:0]          wb_data,
    output logic                              wb_we,
    output logic [exe_pkg::reg_index_w-1:0]   wb_index,
    output logic [exe_pkg::xlen-1:0]          wb_pc
);
    import exe_pkg::*;

    // decode to execute link
    logic                   id_valid;
    logic                   id_ready;
    alu_op_e                id_op;
    logic                   id_inst_ok;
    logic [xlen-1:0]        id_src1;
    logic [xlen-1:0]        id_src2;
    logic                   id_wreg_en;
    logic [reg_index_w-1:0] id_wreg_index;
    logic [xlen-1:0]        id_pc;

    id_stage i_id_stage (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .inst          (inst),
        .pc            (pc),
        .rj_value      (rj_value),
        .rk_value      (rk_value),
        .id_valid      (id_valid),
        .id_ready      (id_ready),
        .id_op         (id_op),
        .id_inst_ok    (id_inst_ok),
        .id_src1       (id_src1),
        .id_src2       (id_src2),
        .id_wreg_en    (id_wreg_en),
        .id_wreg_index (id_wreg_index),
        .id_pc         (id_pc)
    );

    exe_stage i_exe_stage (
        .clk           (clk),
        .rst           (rst),
        .id_valid      (id_valid),
        .id_ready      (id_ready),
        .id_op         (id_op),
        .id_inst_ok    (id_inst_ok),
        .id_src1       (id_src1),
        .id_src2       (id_src2),
        .id_wreg_en    (id_wreg_en),
        .id_wreg_index (id_wreg_index),
        .id_pc         (id_pc),
        .wb_valid      (wb_valid),
        .wb_ready      (wb_ready),
        .wb_data       (wb_data),
        .wb_we         (wb_we),
        .wb_index      (wb_index),
        .wb_pc         (wb_pc)
    );

endmodule

// File: exe_stage.sv
module exe_stage (
    input  logic                              clk,
    input  logic                              rst,
    // decoded bundle from decode
    input  logic                              id_valid,
    output logic                              id_ready,
    input  exe_pkg::alu_op_e                  id_op,
    input  logic                              id_inst_ok,
    input  logic [exe_pkg::xlen-1:0]          id_src1,
    input  logic [exe_pkg::xlen-1:0]          id_src2,
    input  logic                              id_wreg_en,
    input  logic [exe_pkg::reg_index_w-1:0]   id_wreg_index,
    input  logic [exe_pkg::xlen-1:0]          id_pc,
    // result to writeback
    output logic                              wb_valid,
    input  logic                              wb_ready,
    output logic [exe_pkg::xlen-1:0]          wb_data,
    output logic                              wb_we,
    output logic [exe_pkg::reg_index_w-1:0]   wb_index,
    output logic [exe_pkg::xlen-1:0]          wb_pc
);
    import exe_pkg::*;

    logic [xlen-1:0] alu_result;
    logic            valid_q;
    logic            fire_in;
    logic            fire_out;

    alu i_alu (
        .op     (id_op),
        .src1   (id_src1),
        .src2   (id_src2),
        .result (alu_result)
    );

    // ready when empty or when the held result leaves this cycle
    assign id_ready = !valid_q || wb_ready;
    assign fire_in  = id_valid && id_ready;
    assign fire_out = valid_q && wb_ready;
    assign wb_valid = valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fire_in) begin
            valid_q <= 1'b1;  // refill, possibly while draining
        end else if (fire_out) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_in) begin
            wb_data  <= id_inst_ok ? alu_result : '0; // bad opcode gives zero
            wb_we    <= id_wreg_en;
            wb_index <= id_wreg_index;
            wb_pc    <= id_pc;
        end
    end

    // decode must never let an r0 write through
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> !(wb_we && (wb_index == '0)));

    // result held steady while writeback stalls
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable({wb_data, wb_we, wb_index, wb_pc}));

endmodule

// File: id_stage.sv
module id_stage (
    input  logic                              clk,
    input  logic                              rst,
    // issue side
    input  logic                              issue_valid,
    output logic                              issue_ready,
    input  logic [exe_pkg::xlen-1:0]          inst,
    input  logic [exe_pkg::xlen-1:0]          pc,
    input  logic [exe_pkg::xlen-1:0]          rj_value,
    input  logic [exe_pkg::xlen-1:0]          rk_value,
    // decoded bundle to execute
    output logic                              id_valid,
    input  logic                              id_ready,
    output exe_pkg::alu_op_e                  id_op,
    output logic                              id_inst_ok,
    output logic [exe_pkg::xlen-1:0]          id_src1,
    output logic [exe_pkg::xlen-1:0]          id_src2,
    output logic                              id_wreg_en,
    output logic [exe_pkg::reg_index_w-1:0]   id_wreg_index,
    output logic [exe_pkg::xlen-1:0]          id_pc
);
    import exe_pkg::*;

    logic [op_w-1:0]        opcode;
    alu_op_e                op_dec;
    logic                   inst_ok;
    logic [imm_w-1:0]       imm_raw;
    logic [xlen-1:0]        imm_ext;
    logic [xlen-1:0]        src2_sel;
    logic [reg_index_w-1:0] rd;
    logic                   wen;
    logic                   valid_q;
    logic                   fire_in;
    logic                   fire_out;

    // field extraction
    assign opcode  = inst[op_lsb +: op_w];
    assign op_dec  = alu_op_e'(opcode);
    assign imm_raw = inst[imm_w-1:0];
    assign rd      = inst[rd_lsb +: reg_index_w];

    always_comb begin
        case (op_dec)
            op_add, op_sub, op_slt, op_sltu, op_and, op_or,
            op_nor, op_xor, op_sll, op_srl, op_sra, op_lui: begin
                inst_ok = 1'b1;
            end
            default: begin
                inst_ok = 1'b0; // codes 12..15
            end
        endcase
    end

    // lui puts the immediate in the upper half, all others sign-extend
    always_comb begin
        if (op_dec == op_lui) begin
            imm_ext = {imm_raw, {(xlen-imm_w){1'b0}}};
        end else begin
            imm_ext = {{(xlen-imm_w){imm_raw[imm_w-1]}}, imm_raw};
        end
    end

    assign src2_sel = inst[use_imm_bit] ? imm_ext : rk_value;
    assign wen      = inst_ok && (rd != '0); // r0 writes are dropped

    // one-slot handshake
    assign issue_ready = !valid_q || id_ready;  // empty or draining
    assign fire_in     = issue_valid && issue_ready;
    assign fire_out    = valid_q && id_ready;
    assign id_valid    = valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fire_in) begin
            valid_q <= 1'b1;
        end else if (fire_out) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_in) begin
            id_op         <= op_dec;
            id_inst_ok    <= inst_ok;
            id_src1       <= rj_value;
            id_src2       <= src2_sel;
            id_wreg_en    <= wen;
            id_wreg_index <= rd;
            id_pc         <= pc;
        end
    end

    // a stalled bundle stays put until execute takes it
    a_id_hold: assert property (@(posedge clk) disable iff (rst)
        id_valid && !id_ready |=> id_valid && $stable({id_op, id_inst_ok, id_src1,
            id_src2, id_wreg_en, id_wreg_index, id_pc}));

endmodule

// File: alu.sv
module alu (
    input  exe_pkg::alu_op_e          op,
    input  logic [exe_pkg::xlen-1:0]  src1,
    input  logic [exe_pkg::xlen-1:0]  src2,
    output logic [exe_pkg::xlen-1:0]  result
);
    import exe_pkg::*;

    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0]    sum;
    logic [xlen-1:0]    diff;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = src2[shamt_w-1:0];       // low bits only
    assign sum         = src1 + src2;
    assign diff        = src1 - src2;
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            op_add: begin
                result = sum;
            end
            op_sub: begin
                result = diff;
            end
            op_slt: begin
                result = {{(xlen-1){1'b0}}, lt_signed};
            end
            op_sltu: begin
                result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            op_and: begin
                result = src1 & src2;
            end
            op_or: begin
                result = src1 | src2;
            end
            op_nor: begin
                result = ~(src1 | src2);
            end
            op_xor: begin
                result = src1 ^ src2;
            end
            op_sll: begin
                result = src1 << shamt;
            end
            op_srl: begin
                result = src1 >> shamt;
            end
            op_sra: begin
                result = $unsigned($signed(src1) >>> shamt); // sign fill
            end
            op_lui: begin
                result = src2; // immediate already shifted in decode
            end
            default: begin
                result = '0; // undefined code
            end
        endcase
    end

endmodule

// File: exe_pkg.sv
package exe_pkg;

    localparam int xlen        = 32; // data and address width
    localparam int reg_index_w = 5;  // register file index width
    localparam int shamt_w     = 5;  // shift amount width

    // instruction word layout
    localparam int op_lsb      = 28; // opcode in bits 31..28
    localparam int op_w        = 4;
    localparam int use_imm_bit = 27; // immediate replaces rk_value
    localparam int rd_lsb      = 22; // destination in bits 26..22
    localparam int imm_w       = 16; // immediate in bits 15..0

    // ALU operation codes, 12..15 left undefined
    typedef enum logic [op_w-1:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_slt  = 4'd2,  // signed compare
        op_sltu = 4'd3,  // unsigned compare
        op_and  = 4'd4,
        op_or   = 4'd5,
        op_nor  = 4'd6,
        op_xor  = 4'd7,
        op_sll  = 4'd8,
        op_srl  = 4'd9,
        op_sra  = 4'd10,
        op_lui  = 4'd11  // passes the upper immediate through
    } alu_op_e;

endpackage
